// ==== src/clint_defines.svh ====
////////////////////////////////////////
// Bus widths, register map and synchronizer depth of the CLINT
// Included by the package and by every block that needs a constant
////////////////////////////////////////

`ifndef CLINT_DEFINES_SVH
`define CLINT_DEFINES_SVH

// Peripheral bus widths
`define CLINT_ADDRW 16
`define CLINT_XLEN 32

// Flip-flop stages between the rtc pin and the aclk domain
`define CLINT_SYNC_DEPTH 2

// Register byte offsets, sized to the bus address width
`define CLINT_OFS_MSIP 16'h0000
`define CLINT_OFS_MTIME_LO 16'h0004
`define CLINT_OFS_MTIME_HI 16'h0008
`define CLINT_OFS_MTIMECMP_LO 16'h000C
`define CLINT_OFS_MTIMECMP_HI 16'h0010

`endif

// ==== src/clint_pkg.sv ====
////////////////////////////////////////
// Shared bus types and enums of the CLINT
////////////////////////////////////////

`include "clint_defines.svh"

package clint_pkg;

    // Peripheral bus fields
    typedef logic [`CLINT_ADDRW-1:0] addr_t;
    typedef logic [`CLINT_XLEN-1:0] data_t;
    typedef logic [`CLINT_XLEN/8-1:0] strb_t;

    // Machine time is 64 bits wide whatever the bus width
    typedef logic [63:0] time_t;

    // Register selected by the bus address
    typedef enum logic [2:0] {
        REG_MSIP,
        REG_MTIME_LO,
        REG_MTIME_HI,
        REG_MTIMECMP_LO,
        REG_MTIMECMP_HI,
        REG_NONE
    } clint_reg_e;

    // Slave handshake state
    typedef enum logic {
        ST_IDLE,
        ST_READY
    } bus_state_e;

endpackage

// ==== src/rtc_tick_sync.sv ====
////////////////////////////////////////
// Brings the asynchronous rtc level into aclk
// and gives a one-cycle tick per rising edge
////////////////////////////////////////

`timescale 1ns/100ps

`include "clint_defines.svh"

module rtc_tick_sync (
    input  logic aclk,
    input  logic aresetn,
    input  logic rtc,
    output logic tick
);

    // Synchronizer chain, rtc enters at bit 0
    logic [`CLINT_SYNC_DEPTH-1:0] sync_q;
    // Last synchronized level, for the edge detect
    logic rtc_prev;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            sync_q   <= '0;
            rtc_prev <= 1'b0;
            tick     <= 1'b0;
        end else begin
            sync_q   <= {sync_q[`CLINT_SYNC_DEPTH-2:0], rtc};
            rtc_prev <= sync_q[`CLINT_SYNC_DEPTH-1];
            // Registered so tick lands one cycle after the chain output rises
            tick     <= sync_q[`CLINT_SYNC_DEPTH-1] & ~rtc_prev;
        end
    end

endmodule

// ==== src/clint_regs.sv ====
////////////////////////////////////////
// Bus slave of the CLINT, holds MSIP and MTIMECMP
// and forwards MTIME writes to the time counter
////////////////////////////////////////

`timescale 1ns/100ps

`include "clint_defines.svh"

module clint_regs (
    input  logic             aclk,
    input  logic             aresetn,
    // Peripheral bus
    input  logic             slv_en,
    input  logic             slv_wr,
    input  clint_pkg::addr_t slv_addr,
    input  clint_pkg::data_t slv_wdata,
    input  clint_pkg::strb_t slv_strb,
    output clint_pkg::data_t slv_rdata,
    output logic             slv_ready,
    // Time counter side
    input  clint_pkg::time_t mtime,
    output clint_pkg::time_t mtimecmp,
    output logic             mtime_wr_lo,
    output logic             mtime_wr_hi,
    output clint_pkg::data_t mtime_wdata,
    output clint_pkg::strb_t mtime_strb,
    output logic             bus_busy,
    // Software interrupt, the MSIP bit itself
    output logic             sw_irq
);

    import clint_pkg::*;

    clint_reg_e reg_sel;
    bus_state_e state;
    logic       req;
    data_t      rd_word;

    // Merge the strobed byte lanes of a new word into an old one
    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
        data_t merged;
        merged = old_word;
        for (int i = 0; i < $bits(strb_t); i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    ////////////////////////////////////////
    // Address decode and handshake
    ////////////////////////////////////////

    always_comb begin
        case (slv_addr)
            `CLINT_OFS_MSIP:        reg_sel = REG_MSIP;
            `CLINT_OFS_MTIME_LO:    reg_sel = REG_MTIME_LO;
            `CLINT_OFS_MTIME_HI:    reg_sel = REG_MTIME_HI;
            `CLINT_OFS_MTIMECMP_LO: reg_sel = REG_MTIMECMP_LO;
            `CLINT_OFS_MTIMECMP_HI: reg_sel = REG_MTIMECMP_HI;
            default:                reg_sel = REG_NONE;
        endcase
    end

    // A request is served on the edge that raises slv_ready
    assign req       = slv_en && (state == ST_IDLE);
    assign slv_ready = (state == ST_READY);
    assign bus_busy  = slv_en;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  state <= slv_en ? ST_READY : ST_IDLE;
                ST_READY: state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            sw_irq   <= 1'b0;
            mtimecmp <= '0;
        end else if (req && slv_wr) begin
            case (reg_sel)
                REG_MSIP: begin
                    if (slv_strb[0]) begin
                        sw_irq <= slv_wdata[0];
                    end
                end
                REG_MTIMECMP_LO: begin
                    mtimecmp[0 +: `CLINT_XLEN] <=
                        merge_bytes(mtimecmp[0 +: `CLINT_XLEN], slv_wdata, slv_strb);
                end
                REG_MTIMECMP_HI: begin
                    mtimecmp[`CLINT_XLEN +: `CLINT_XLEN] <=
                        merge_bytes(mtimecmp[`CLINT_XLEN +: `CLINT_XLEN], slv_wdata, slv_strb);
                end
                default: ;
            endcase
        end
    end

    // MTIME itself lives in the counter
    assign mtime_wr_lo = req && slv_wr && (reg_sel == REG_MTIME_LO);
    assign mtime_wr_hi = req && slv_wr && (reg_sel == REG_MTIME_HI);
    assign mtime_wdata = slv_wdata;
    assign mtime_strb  = slv_strb;

    ////////////////////////////////////////
    // Read data
    ////////////////////////////////////////

    always_comb begin
        case (reg_sel)
            REG_MSIP:        rd_word = {{(`CLINT_XLEN-1){1'b0}}, sw_irq};
            REG_MTIME_LO:    rd_word = mtime[0 +: `CLINT_XLEN];
            REG_MTIME_HI:    rd_word = mtime[`CLINT_XLEN +: `CLINT_XLEN];
            REG_MTIMECMP_LO: rd_word = mtimecmp[0 +: `CLINT_XLEN];
            REG_MTIMECMP_HI: rd_word = mtimecmp[`CLINT_XLEN +: `CLINT_XLEN];
            default:         rd_word = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (req) begin
            slv_rdata <= rd_word;
        end
    end

endmodule

// ==== src/mtime_counter.sv ====
////////////////////////////////////////
// Machine time register, loaded by bus byte writes
// and counted by the synchronized rtc tick
////////////////////////////////////////

`timescale 1ns/100ps

module mtime_counter (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             tick,
    input  logic             bus_busy,
    input  clint_pkg::time_t mtimecmp,
    // Byte writes from the bus slave
    input  logic             mtime_wr_lo,
    input  logic             mtime_wr_hi,
    input  clint_pkg::data_t mtime_wdata,
    input  clint_pkg::strb_t mtime_strb,
    output clint_pkg::time_t mtime
);

    import clint_pkg::*;

    time_t load_value;
    int    lane_base;

    // Strobed lanes of the addressed half, the rest keeps its value
    always_comb begin
        lane_base  = mtime_wr_hi ? $bits(data_t) : 0;
        load_value = mtime;
        for (int i = 0; i < $bits(strb_t); i++) begin
            if (mtime_strb[i]) begin
                load_value[lane_base + 8*i +: 8] = mtime_wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mtime <= '0;
        end else if (mtime_wr_lo || mtime_wr_hi) begin
            mtime <= load_value;
        end else if (mtimecmp == '0) begin
            // Timer disabled while the compare value is zero
            mtime <= '0;
        end else if (tick && !bus_busy) begin
            // A tick that meets a bus access is dropped
            mtime <= mtime + 64'd1;
        end
    end

endmodule

// ==== src/timer_compare.sv ====
////////////////////////////////////////
// Registered MTIME against MTIMECMP compare
// driving the machine timer interrupt
////////////////////////////////////////

`timescale 1ns/100ps

module timer_compare (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             bus_busy,
    input  clint_pkg::time_t mtime,
    input  clint_pkg::time_t mtimecmp,
    output logic             timer_irq
);

    logic cmp_enabled;
    logic time_reached;

    assign cmp_enabled  = (mtimecmp != '0);
    // Both operands are unsigned 64-bit values
    assign time_reached = (mtime >= mtimecmp);

    // The interrupt keeps its level while the bus is being accessed
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            timer_irq <= 1'b0;
        end else if (!bus_busy) begin
            timer_irq <= cmp_enabled && time_reached;
        end
    end

endmodule

// ==== src/clint_top.sv ====
////////////////////////////////////////
// CLINT top level, one hart, 32-bit peripheral bus
////////////////////////////////////////

`timescale 1ns/100ps

module clint_top (
    input  logic             aclk,
    input  logic             aresetn,
    // Peripheral bus
    input  logic             slv_en,
    input  logic             slv_wr,
    input  clint_pkg::addr_t slv_addr,
    input  clint_pkg::data_t slv_wdata,
    input  clint_pkg::strb_t slv_strb,
    output clint_pkg::data_t slv_rdata,
    output logic             slv_ready,
    // Real-time clock, asynchronous to aclk
    input  logic             rtc,
    // Interrupts to the hart
    output logic             sw_irq,
    output logic             timer_irq
);

    import clint_pkg::*;

    logic  tick;
    logic  bus_busy;
    logic  mtime_wr_lo;
    logic  mtime_wr_hi;
    data_t mtime_wdata;
    strb_t mtime_strb;
    time_t mtime;
    time_t mtimecmp;

    rtc_tick_sync rtc_tick_sync_inst (
        .aclk    (aclk),
        .aresetn (aresetn),
        .rtc     (rtc),
        .tick    (tick)
    );

    clint_regs clint_regs_inst (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .slv_en      (slv_en),
        .slv_wr      (slv_wr),
        .slv_addr    (slv_addr),
        .slv_wdata   (slv_wdata),
        .slv_strb    (slv_strb),
        .slv_rdata   (slv_rdata),
        .slv_ready   (slv_ready),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .mtime_wr_lo (mtime_wr_lo),
        .mtime_wr_hi (mtime_wr_hi),
        .mtime_wdata (mtime_wdata),
        .mtime_strb  (mtime_strb),
        .bus_busy    (bus_busy),
        .sw_irq      (sw_irq)
    );

    mtime_counter mtime_counter_inst (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .tick        (tick),
        .bus_busy    (bus_busy),
        .mtimecmp    (mtimecmp),
        .mtime_wr_lo (mtime_wr_lo),
        .mtime_wr_hi (mtime_wr_hi),
        .mtime_wdata (mtime_wdata),
        .mtime_strb  (mtime_strb),
        .mtime       (mtime)
    );

    timer_compare timer_compare_inst (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .bus_busy  (bus_busy),
        .mtime     (mtime),
        .mtimecmp  (mtimecmp),
        .timer_irq (timer_irq)
    );

endmodule

// ==== testbench/clint_properties.sv ====
////////////////////////////////////////
// Bus handshake and interrupt assertions,
// bound into every clint_top instance
////////////////////////////////////////

`timescale 1ns/100ps

module clint_properties (
    input logic aclk,
    input logic aresetn,
    input logic slv_en,
    input logic slv_ready,
    input logic sw_irq,
    input logic timer_irq
);

    // Ready only answers a live request
    ready_needs_en: assert property (@(posedge aclk) disable iff (!aresetn)
        slv_ready |-> slv_en)
        else $error("slv_ready high without slv_en");

    // One ready pulse per request
    ready_single: assert property (@(posedge aclk) disable iff (!aresetn)
        slv_ready |=> !slv_ready)
        else $error("slv_ready high for two cycles");

    // Fixed latency of one cycle
    ready_latency: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(slv_en) |=> slv_ready)
        else $error("slv_ready missing one cycle after slv_en rose");

    irq_known: assert property (@(posedge aclk) disable iff (!aresetn)
        !$isunknown(sw_irq) && !$isunknown(timer_irq))
        else $error("interrupt output unknown");

endmodule

bind clint_top clint_properties clint_properties_inst (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .slv_en    (slv_en),
    .slv_ready (slv_ready),
    .sw_irq    (sw_irq),
    .timer_irq (timer_irq)
);

// ==== testbench/clint_tb.sv ====
////////////////////////////////////////
// Testbench for the CLINT that drives the bus and rtc
// and checks reads and interrupts against a reference model
////////////////////////////////////////

`timescale 1ns/100ps

`include "clint_defines.svh"

module clint_tb;

    import clint_pkg::*;

    localparam int NUM_TESTS = 6;
    localparam int MAX_PULSES = 8;
    localparam int PULSE_CYCLES = 12;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * MAX_PULSES * PULSE_CYCLES + 2000;
    localparam int READY_LIMIT = 8;

    logic  aclk;
    logic  aresetn;
    logic  slv_en;
    logic  slv_wr;
    addr_t slv_addr;
    data_t slv_wdata;
    strb_t slv_strb;
    data_t slv_rdata;
    logic  slv_ready;
    logic  rtc;
    logic  sw_irq;
    logic  timer_irq;

    // Reference model state
    logic  model_msip = 1'b0;
    time_t model_mtime = '0;
    time_t model_mtimecmp = '0;

    // Reads waiting for the compare process
    string name_q[$];
    data_t got_q[$];
    data_t exp_q[$];

    clint_top clint_top_inst (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .slv_en    (slv_en),
        .slv_wr    (slv_wr),
        .slv_addr  (slv_addr),
        .slv_wdata (slv_wdata),
        .slv_strb  (slv_strb),
        .slv_rdata (slv_rdata),
        .slv_ready (slv_ready),
        .rtc       (rtc),
        .sw_irq    (sw_irq),
        .timer_irq (timer_irq)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("simulation timed out before all tests finished");
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic data_t lane_mask(input strb_t strb);
        data_t mask;
        for (int i = 0; i < $bits(strb_t); i++) begin
            mask[8*i +: 8] = {8{strb[i]}};
        end
        return mask;
    endfunction

    // Applies ticks, then a write, then returns the read word of sel
    function automatic data_t model_access(input clint_reg_e sel, input logic wr,
                                           input data_t wdata, input strb_t strb,
                                           input int ticks);
        data_t mask;
        mask = lane_mask(strb);
        if (model_mtimecmp != '0) begin
            model_mtime = model_mtime + time_t'(ticks);
        end
        if (wr) begin
            case (sel)
                REG_MSIP:        model_msip = strb[0] ? wdata[0] : model_msip;
                REG_MTIME_LO:    model_mtime[31:0] =
                                     (model_mtime[31:0] & ~mask) | (wdata & mask);
                REG_MTIME_HI:    model_mtime[63:32] =
                                     (model_mtime[63:32] & ~mask) | (wdata & mask);
                REG_MTIMECMP_LO: model_mtimecmp[31:0] =
                                     (model_mtimecmp[31:0] & ~mask) | (wdata & mask);
                REG_MTIMECMP_HI: model_mtimecmp[63:32] =
                                     (model_mtimecmp[63:32] & ~mask) | (wdata & mask);
                default: ;
            endcase
        end
        // A zero compare value holds the timer cleared
        if (model_mtimecmp == '0) begin
            model_mtime = '0;
        end
        case (sel)
            REG_MSIP:        return {31'b0, model_msip};
            REG_MTIME_LO:    return model_mtime[31:0];
            REG_MTIME_HI:    return model_mtime[63:32];
            REG_MTIMECMP_LO: return model_mtimecmp[31:0];
            REG_MTIMECMP_HI: return model_mtimecmp[63:32];
            default:         return '0;
        endcase
    endfunction

    function automatic addr_t reg_addr(input clint_reg_e sel);
        case (sel)
            REG_MSIP:        return `CLINT_OFS_MSIP;
            REG_MTIME_LO:    return `CLINT_OFS_MTIME_LO;
            REG_MTIME_HI:    return `CLINT_OFS_MTIME_HI;
            REG_MTIMECMP_LO: return `CLINT_OFS_MTIMECMP_LO;
            REG_MTIMECMP_HI: return `CLINT_OFS_MTIMECMP_HI;
            default:         return 16'h0020;
        endcase
    endfunction

    ////////////////////////////////////////
    // Checks and compare process
    ////////////////////////////////////////

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s read %h expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1, "register value mismatch");
        end
    endtask

    task automatic check_irq(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s is %b expected %b", $time, name, got, exp);
            $display("test failed");
            $fatal(1, "interrupt level mismatch");
        end
    endtask

    initial begin
        forever begin
            @(posedge aclk);
            while (name_q.size() > 0) begin
                check_data(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
            end
        end
    end

    ////////////////////////////////////////
    // Bus and rtc drivers called on a falling edge
    ////////////////////////////////////////

    // Returns in the cycle after slv_ready with slv_en still high
    task automatic bus_access(input logic wr, input addr_t addr, input data_t data,
                              input strb_t strb, output data_t rdata);
        int waited;
        waited = 0;
        slv_en    = 1'b1;
        slv_wr    = wr;
        slv_addr  = addr;
        slv_wdata = data;
        slv_strb  = strb;
        @(negedge aclk);
        while (slv_ready !== 1'b1) begin
            if (waited == READY_LIMIT) begin
                $display("no slv_ready from the DUT within %0d cycles", READY_LIMIT);
                $display("test failed");
                $fatal(1, "bus handshake timeout");
            end
            waited++;
            @(negedge aclk);
        end
        rdata = slv_rdata;
        @(negedge aclk);
    endtask

    task automatic bus_release();
        slv_en = 1'b0;
        slv_wr = 1'b0;
        @(negedge aclk);
    endtask

    task automatic access_reg(input logic wr, input clint_reg_e sel, input data_t data,
                              input strb_t strb);
        data_t got;
        data_t exp;
        bus_access(wr, reg_addr(sel), data, strb, got);
        exp = model_access(sel, wr, data, strb, 0);
        if (!wr) begin
            name_q.push_back(sel.name());
            got_q.push_back(got);
            exp_q.push_back(exp);
        end
    endtask

    task automatic bus_write(input clint_reg_e sel, input data_t data, input strb_t strb);
        access_reg(1'b1, sel, data, strb);
        bus_release();
    endtask

    task automatic bus_read(input clint_reg_e sel);
        access_reg(1'b0, sel, '0, '0);
        bus_release();
    endtask

    task automatic read_all();
        for (int r = 0; r <= int'(REG_NONE); r++) begin
            bus_read(clint_reg_e'(r));
        end
    endtask

    task automatic idle_wait(input int cycles);
        repeat (cycles) @(negedge aclk);
    endtask

    task automatic rtc_pulses(input int count);
        repeat (count) begin
            rtc = 1'b1;
            idle_wait(6);
            rtc = 1'b0;
            idle_wait(6);
        end
        void'(model_access(REG_NONE, 1'b0, '0, '0, count));
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        int    n;
        int    k;
        data_t lo;
        time_t target;
        aresetn   = 1'b0;
        slv_en    = 1'b0;
        slv_wr    = 1'b0;
        slv_addr  = '0;
        slv_wdata = '0;
        slv_strb  = '0;
        rtc       = 1'b0;
        void'($urandom(22515));
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);

        // Reset values and a write to an unmapped address
        check_irq("sw_irq", sw_irq, 1'b0);
        check_irq("timer_irq", timer_irq, 1'b0);
        read_all();
        bus_write(REG_NONE, $urandom, 4'hF);
        read_all();

        // MSIP and the software interrupt
        bus_write(REG_MSIP, 32'h1, 4'h1);
        check_irq("sw_irq", sw_irq, model_msip);
        bus_read(REG_MSIP);
        bus_write(REG_MSIP, 32'h0, 4'hE);
        check_irq("sw_irq", sw_irq, model_msip);
        bus_read(REG_MSIP);
        bus_write(REG_MSIP, 32'h0, 4'h1);
        check_irq("sw_irq", sw_irq, model_msip);
        bus_read(REG_MSIP);

        // Strobed MTIMECMP writes
        repeat (4) begin
            bus_write(REG_MTIMECMP_LO, $urandom, strb_t'($urandom_range(0, 15)));
            bus_write(REG_MTIMECMP_HI, $urandom, strb_t'($urandom_range(0, 15)));
            read_all();
        end

        // MTIME load and count with a low word that carries
        bus_write(REG_MTIMECMP_HI, 32'hFFFF_FFFF, 4'hF);
        bus_write(REG_MTIMECMP_LO, $urandom | 32'h1, 4'hF);
        n = $urandom_range(1, MAX_PULSES);
        lo = 32'hFFFF_FFFF - data_t'($urandom_range(0, n - 1));
        bus_write(REG_MTIME_LO, lo, 4'hF);
        bus_write(REG_MTIME_HI, $urandom, strb_t'($urandom_range(1, 15)));
        read_all();
        rtc_pulses(n);
        read_all();
        bus_write(REG_MTIMECMP_LO, 32'h0, 4'hF);
        bus_write(REG_MTIMECMP_HI, 32'h0, 4'hF);
        read_all();

        // Timer interrupt at MTIME plus K
        bus_write(REG_MTIMECMP_HI, 32'hFFFF_FFFF, 4'hF);
        bus_write(REG_MTIME_LO, data_t'($urandom_range(0, 1000)), 4'hF);
        bus_write(REG_MTIME_HI, 32'h0, 4'hF);
        k = $urandom_range(2, MAX_PULSES);
        target = model_mtime + time_t'(k);
        bus_write(REG_MTIMECMP_LO, target[31:0], 4'hF);
        bus_write(REG_MTIMECMP_HI, target[63:32], 4'hF);
        rtc_pulses(k - 1);
        idle_wait(8);
        check_irq("timer_irq", timer_irq, 1'b0);
        rtc_pulses(1);
        idle_wait(8);
        check_irq("timer_irq", timer_irq, 1'b1);
        bus_write(REG_MTIMECMP_LO, 32'h0, 4'hF);
        bus_write(REG_MTIMECMP_HI, 32'h0, 4'hF);
        idle_wait(8);
        check_irq("timer_irq", timer_irq, 1'b0);
        bus_read(REG_MTIME_LO);

        // Back-to-back requests with slv_en held between them
        access_reg(1'b1, REG_MTIMECMP_LO, $urandom, 4'hF);
        access_reg(1'b1, REG_MTIMECMP_HI, $urandom | 32'h1, 4'hF);
        access_reg(1'b0, REG_MTIMECMP_LO, '0, '0);
        access_reg(1'b0, REG_MTIMECMP_HI, '0, '0);
        access_reg(1'b1, REG_MSIP, 32'h1, 4'h1);
        access_reg(1'b0, REG_MSIP, '0, '0);
        access_reg(1'b1, REG_MTIME_LO, $urandom, 4'hF);
        access_reg(1'b0, REG_MTIME_LO, '0, '0);
        access_reg(1'b1, REG_NONE, $urandom, 4'hF);
        access_reg(1'b0, REG_NONE, '0, '0);
        access_reg(1'b0, REG_MTIME_HI, '0, '0);
        bus_release();
        check_irq("sw_irq", sw_irq, model_msip);

        @(posedge aclk);
        @(negedge aclk);
        if (name_q.size() != 0) begin
            $display("reads were left without a comparison");
            $display("test failed");
            $fatal(1, "unfinished comparisons");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== clint_top.f ====
+incdir+src
src/clint_pkg.sv
src/rtc_tick_sync.sv
src/clint_regs.sv
src/mtime_counter.sv
src/timer_compare.sv
src/clint_top.sv
testbench/clint_properties.sv
testbench/clint_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the CLINT testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module clint_tb -f clint_top.f -o clint_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/clint_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "test passed"; then
    exit 0
fi

echo "pass message not found in the simulation output"
exit 1
